// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/100ps
TOP      := tb_spi_master
FILELIST := all.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== all.f ====
+incdir+.
spi_master_pkg.sv
async_fifo.sv
spi_bus_port.sv
spi_shifter.sv
spi_master.sv
tb_spi_master.sv

// ==== async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  AW        = 4
) (
   input  wire      rst_i,
   // Write side
   input  wire      wr_clk_i,
   input  wire      wr_en_i,
   input  payload_t wr_data_i,
   output logic     full_o,
   // Read side
   input  wire      rd_clk_i,
   input  wire      rd_en_i,
   output payload_t rd_data_o,
   output logic     empty_o
);

   localparam int DEPTH = 2 ** AW;

   // Pointers carry one extra bit to tell full from empty
   logic [AW:0] wr_bin_q;
   logic [AW:0] wr_gray_q;
   logic [AW:0] rd_bin_q;
   logic [AW:0] rd_gray_q;

   // Gray pointers brought over from the other side, two stages each
   logic [AW:0] rd_gray_w1_q;
   logic [AW:0] rd_gray_w2_q;
   logic [AW:0] wr_gray_r1_q;
   logic [AW:0] wr_gray_r2_q;

   logic [AW:0] wr_bin_next;
   logic [AW:0] rd_bin_next;
   logic        wr_do;
   logic        rd_do;

   payload_t mem [DEPTH];

   // ------------------------------------------------------------------------
   // Write clock domain
   // ------------------------------------------------------------------------

   // Writes into a full FIFO are dropped
   assign wr_do       = wr_en_i && !full_o;
   assign wr_bin_next = wr_bin_q + {{AW{1'b0}}, wr_do};

   always_ff @(posedge wr_clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wr_bin_q  <= '0;
         wr_gray_q <= '0;
      end
      else
      begin
         wr_bin_q  <= wr_bin_next;
         wr_gray_q <= (wr_bin_next >> 1) ^ wr_bin_next;
      end
   end

   // Read pointer into the write domain
   always_ff @(posedge wr_clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rd_gray_w1_q <= '0;
         rd_gray_w2_q <= '0;
      end
      else
      begin
         rd_gray_w1_q <= rd_gray_q;
         rd_gray_w2_q <= rd_gray_w1_q;
      end
   end

   // Full when the write pointer is one lap ahead
   // In gray code that is the two top bits inverted
   assign full_o = wr_gray_q == {~rd_gray_w2_q[AW:AW-1], rd_gray_w2_q[AW-2:0]};

   // Storage has no reset, only the pointers decide what is valid
   always_ff @(posedge wr_clk_i)
   begin
      if (wr_do)
         mem[wr_bin_q[AW-1:0]] <= wr_data_i;
   end

   // ------------------------------------------------------------------------
   // Read clock domain
   // ------------------------------------------------------------------------

   assign rd_do       = rd_en_i && !empty_o;
   assign rd_bin_next = rd_bin_q + {{AW{1'b0}}, rd_do};

   always_ff @(posedge rd_clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rd_bin_q  <= '0;
         rd_gray_q <= '0;
      end
      else
      begin
         rd_bin_q  <= rd_bin_next;
         rd_gray_q <= (rd_bin_next >> 1) ^ rd_bin_next;
      end
   end

   // Write pointer into the read domain
   always_ff @(posedge rd_clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wr_gray_r1_q <= '0;
         wr_gray_r2_q <= '0;
      end
      else
      begin
         wr_gray_r1_q <= wr_gray_q;
         wr_gray_r2_q <= wr_gray_r1_q;
      end
   end

   // Empty when both pointers match, head shown without a read latency
   assign empty_o   = rd_gray_q == wr_gray_r2_q;
   assign rd_data_o = mem[rd_bin_q[AW-1:0]];

endmodule

`default_nettype wire

// ==== spi_bus_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_bus_port (
   input  wire                       clk_i,
   input  wire                       rst_i,
   // Bus slave port
   input  wire                       cyc_i,
   input  wire                       stb_i,
   input  wire                       we_i,
   input  spi_master_pkg::spi_adr_t  adr_i,
   input  spi_master_pkg::spi_byte_t dat_i,
   output logic                      ack_o,
   output logic                      wat_o,
   output logic                      rdy_o,
   output spi_master_pkg::spi_byte_t dat_o,
   // Transmit FIFO write side
   output logic                      tx_wr_o,
   output spi_master_pkg::tx_entry_t tx_data_o,
   input  wire                       tx_full_i,
   // Receive FIFO read side
   output logic                      rx_rd_o,
   input  spi_master_pkg::spi_byte_t rx_data_i,
   input  wire                       rx_empty_i,
   output logic                      rx_flush_o
);

   // Command byte already written in this bus cycle
   logic busy_q;
   // Data of the first strobe still waiting for a FIFO slot
   logic pend_q;
   // Previous cyc_i, for the falling edge
   logic cyc_q;
   logic accept;

   spi_master_pkg::spi_byte_t hold_q;

   // ------------------------------------------------------------------------
   // Strobe acceptance and write entries
   // ------------------------------------------------------------------------

   // Back-pressure from a full FIFO or a deferred entry not yet written
   assign wat_o = tx_full_i || pend_q;

   // The strobe stays up in the ack cycle, it must not count twice
   assign accept = cyc_i && stb_i && !wat_o && !ack_o;

   // The deferred data entry retries until the FIFO has room
   assign tx_wr_o = accept || (pend_q && !tx_full_i);

   always_comb
   begin
      tx_data_o.first = 1'b0;
      tx_data_o.data  = dat_i;
      if (pend_q)
      begin
         tx_data_o.data = hold_q;
      end
      else if (!busy_q)
      begin
         // First strobe of the cycle, command is {we, adr}
         tx_data_o.first = 1'b1;
         tx_data_o.data  = {we_i, adr_i};
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         busy_q <= 1'b0;
         pend_q <= 1'b0;
         ack_o  <= 1'b0;
      end
      else
      begin
         ack_o  <= accept;
         // Busy lasts until the master ends the cycle
         busy_q <= cyc_i && (busy_q || accept);
         if (accept && !busy_q)
            pend_q <= 1'b1;
         else if (!tx_full_i)
            pend_q <= 1'b0;
      end
   end

   // Copy of dat_i for the entry written one cycle late
   always_ff @(posedge clk_i)
   begin
      if (accept && !busy_q)
         hold_q <= dat_i;
   end

   // ------------------------------------------------------------------------
   // Read back and flush
   // ------------------------------------------------------------------------

   // One pop per two cycles at most, rdy_o low between pulses
   assign rx_rd_o = !rx_empty_i && !rdy_o;

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rdy_o      <= 1'b0;
         cyc_q      <= 1'b0;
         rx_flush_o <= 1'b0;
      end
      else
      begin
         rdy_o <= rx_rd_o;
         cyc_q <= cyc_i;
         // Single pulse when the cycle ends
         rx_flush_o <= cyc_q && !cyc_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rx_rd_o)
         dat_o <= rx_data_i;
   end

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_master_defines.svh"

module spi_master (
   input  wire                       clk_i,
   input  wire                       rst_i,
   // Bus slave port
   input  wire                       cyc_i,
   input  wire                       stb_i,
   input  wire                       we_i,
   input  spi_master_pkg::spi_adr_t  adr_i,
   input  spi_master_pkg::spi_byte_t dat_i,
   output logic                      ack_o,
   output logic                      wat_o,
   output logic                      rdy_o,
   output spi_master_pkg::spi_byte_t dat_o,
   // SPI side
   input  wire                       sck_i,
   input  wire                       miso_i,
   output logic                      sck_en_o,
   output logic                      ssel_o,
   output logic                      mosi_o
);

   // Transmit path, bus to SPI
   logic                      tx_wr;
   logic                      tx_rd;
   logic                      tx_full;
   logic                      tx_empty;
   spi_master_pkg::tx_entry_t tx_wr_data;
   spi_master_pkg::tx_entry_t tx_rd_data;

   // Receive path, SPI to bus
   logic                      rx_wr;
   logic                      rx_rd;
   logic                      rx_empty;
   logic                      rx_flush;
   logic                      rx_rst;
   spi_master_pkg::spi_byte_t rx_wr_data;
   spi_master_pkg::spi_byte_t rx_rd_data;

   // Flush clears both sides of the return FIFO
   assign rx_rst = rst_i || rx_flush;

   spi_bus_port u_bus_port (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .ack_o      (ack_o),
      .wat_o      (wat_o),
      .rdy_o      (rdy_o),
      .dat_o      (dat_o),
      .tx_wr_o    (tx_wr),
      .tx_data_o  (tx_wr_data),
      .tx_full_i  (tx_full),
      .rx_rd_o    (rx_rd),
      .rx_data_i  (rx_rd_data),
      .rx_empty_i (rx_empty),
      .rx_flush_o (rx_flush)
   );

   async_fifo #(
      .payload_t (spi_master_pkg::tx_entry_t),
      .AW        (`SPI_FIFO_AW)
   ) tx_fifo (
      .rst_i     (rst_i),
      .wr_clk_i  (clk_i),
      .wr_en_i   (tx_wr),
      .wr_data_i (tx_wr_data),
      .full_o    (tx_full),
      .rd_clk_i  (sck_i),
      .rd_en_i   (tx_rd),
      .rd_data_o (tx_rd_data),
      .empty_o   (tx_empty)
   );

   // The bus side drains every returned byte, so full is never consulted
   async_fifo #(
      .payload_t (spi_master_pkg::spi_byte_t),
      .AW        (`SPI_FIFO_AW)
   ) rx_fifo (
      .rst_i     (rx_rst),
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_wr),
      .wr_data_i (rx_wr_data),
      .full_o    (),
      .rd_clk_i  (clk_i),
      .rd_en_i   (rx_rd),
      .rd_data_o (rx_rd_data),
      .empty_o   (rx_empty)
   );

   spi_shifter u_shifter (
      .sck_i      (sck_i),
      .rst_i      (rst_i),
      .cyc_i      (cyc_i),
      .tx_rd_o    (tx_rd),
      .tx_data_i  (tx_rd_data),
      .tx_empty_i (tx_empty),
      .rx_wr_o    (rx_wr),
      .rx_data_o  (rx_wr_data),
      .miso_i     (miso_i),
      .mosi_o     (mosi_o),
      .sck_en_o   (sck_en_o),
      .ssel_o     (ssel_o)
   );

endmodule

`default_nettype wire

// ==== spi_master_defines.svh ====
`ifndef SPI_MASTER_DEFINES_SVH
`define SPI_MASTER_DEFINES_SVH

// ---------------------------------------------------------------------------
// Sizes shared by the SPI master
// ---------------------------------------------------------------------------

// Log2 of the depth of each clock-crossing FIFO, 16 entries
`define SPI_FIFO_AW 4

// Bus address width
// Together with we_i it fills exactly one command byte
`define SPI_ADR_W 7

// Width of one serial byte on mosi_o and miso_i
`define SPI_BYTE_W 8

`endif

// ==== spi_master_pkg.sv ====
`default_nettype none

`include "spi_master_defines.svh"

package spi_master_pkg;

   // One byte as it moves over the SPI wires
   typedef logic [`SPI_BYTE_W-1:0] spi_byte_t;

   // Register address presented on the bus
   typedef logic [`SPI_ADR_W-1:0] spi_adr_t;

   // Entry of the transmit FIFO
   // first marks the command byte that opens an SPI transaction
   typedef struct packed {
      logic      first;
      spi_byte_t data;
   } tx_entry_t;

endpackage

`default_nettype wire

// ==== spi_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_master_defines.svh"

module spi_shifter (
   input  wire                       sck_i,
   input  wire                       rst_i,
   input  wire                       cyc_i,
   // Transmit FIFO read side
   output logic                      tx_rd_o,
   input  spi_master_pkg::tx_entry_t tx_data_i,
   input  wire                       tx_empty_i,
   // Receive FIFO write side
   output logic                      rx_wr_o,
   output spi_master_pkg::spi_byte_t rx_data_o,
   // SPI wires
   input  wire                       miso_i,
   output logic                      mosi_o,
   output logic                      sck_en_o,
   output logic                      ssel_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_SEND
   } state_t;

   state_t state_q;
   logic [2:0] bit_cnt_q;
   logic cyc_meta_q;
   logic cyc_sync_q;
   logic last_bit;
   logic may_pop;

   spi_master_pkg::spi_byte_t tx_sr_q;
   spi_master_pkg::spi_byte_t rx_sr_q;

   // ------------------------------------------------------------------------
   // FIFO pop decision
   // ------------------------------------------------------------------------

   assign last_bit = state_q == ST_SEND && bit_cnt_q == 3'd7;

   // A command byte opens a new window
   // Inside a running window it is held back until ssel_o has risen
   assign may_pop = !tx_empty_i && (!tx_data_i.first || state_q == ST_IDLE);
   assign tx_rd_o = may_pop && (state_q != ST_SEND || last_bit);

   // Bus cycle level into the SPI clock
   always_ff @(posedge sck_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         cyc_meta_q <= 1'b0;
         cyc_sync_q <= 1'b0;
      end
      else
      begin
         cyc_meta_q <= cyc_i;
         cyc_sync_q <= cyc_meta_q;
      end
   end

   // ------------------------------------------------------------------------
   // Rising edge, state machine and select
   // ------------------------------------------------------------------------

   always_ff @(posedge sck_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q   <= ST_IDLE;
         bit_cnt_q <= 3'd0;
         ssel_o    <= 1'b1;
         rx_wr_o   <= 1'b0;
      end
      else
      begin
         // Captured byte is complete after the eighth sample
         rx_wr_o <= last_bit;
         case (state_q)
            ST_IDLE:
            begin
               if (tx_rd_o)
               begin
                  ssel_o    <= 1'b0;
                  bit_cnt_q <= 3'd0;
                  state_q   <= ST_SEND;
               end
            end
            ST_SEND:
            begin
               bit_cnt_q <= bit_cnt_q + 3'd1;
               // Back-to-back bytes keep shifting without a gap
               if (last_bit && !tx_rd_o)
                  state_q <= ST_WAIT;
            end
            ST_WAIT:
            begin
               if (tx_rd_o)
               begin
                  bit_cnt_q <= 3'd0;
                  state_q   <= ST_SEND;
               end
               else if (!tx_empty_i || !cyc_sync_q)
               begin
                  // Next command waiting, or the bus cycle is over
                  ssel_o  <= 1'b1;
                  state_q <= ST_IDLE;
               end
            end
            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   // Transmit register, MSB first
   always_ff @(posedge sck_i)
   begin
      if (tx_rd_o)
         tx_sr_q <= tx_data_i.data;
      else if (state_q == ST_SEND)
         tx_sr_q <= {tx_sr_q[`SPI_BYTE_W-2:0], 1'b0};
   end

   // Receive register samples miso_i on every shifting edge
   always_ff @(posedge sck_i)
   begin
      if (state_q == ST_SEND)
         rx_sr_q <= {rx_sr_q[`SPI_BYTE_W-2:0], miso_i};
   end

   assign rx_data_o = rx_sr_q;

   // ------------------------------------------------------------------------
   // Falling edge, data out and clock enable
   // ------------------------------------------------------------------------

   always_ff @(negedge sck_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         mosi_o   <= 1'b0;
         sck_en_o <= 1'b0;
      end
      else
      begin
         // Outside gating passes SCK only while a byte shifts
         sck_en_o <= state_q == ST_SEND;
         mosi_o   <= (state_q == ST_SEND) && tx_sr_q[`SPI_BYTE_W-1];
      end
   end

endmodule

`default_nettype wire

// ==== tb_spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_spi_master;

   // Transactions in the run, the first one is the 20 byte burst
   localparam int N_TRANS = 12;
   // Budget of 25 bytes per transaction, 8 bits of 60 ns each, four times over
   localparam int WATCHDOG_NS = N_TRANS * 25 * 8 * 60 * 4;

   logic                      clk_i;
   logic                      rst_i;
   logic                      cyc_i;
   logic                      stb_i;
   logic                      we_i;
   spi_master_pkg::spi_adr_t  adr_i;
   spi_master_pkg::spi_byte_t dat_i;
   logic                      ack_o;
   logic                      wat_o;
   logic                      rdy_o;
   spi_master_pkg::spi_byte_t dat_o;
   logic                      sck_i;
   logic                      miso_i;
   logic                      sck_en_o;
   logic                      ssel_o;
   logic                      mosi_o;

   // Random state for bus stimulus and for slave replies
   logic [15:0] stim_lfsr;
   logic [15:0] slv_lfsr;

   // Bytes seen by the slave, window-start flags and replies still owed to the bus
   spi_master_pkg::spi_byte_t mosi_q[$];
   logic                      first_q[$];
   spi_master_pkg::spi_byte_t reply_q[$];
   spi_master_pkg::spi_byte_t exp_q[$];

   // Bus monitor state
   logic prev_cyc;
   logic prev_stb;
   logic prev_wat;
   logic prev_ack;
   logic prev_rdy;
   int   rdy_count;
   int   wat_cycles;

   spi_master dut (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .ack_o    (ack_o),
      .wat_o    (wat_o),
      .rdy_o    (rdy_o),
      .dat_o    (dat_o),
      .sck_i    (sck_i),
      .miso_i   (miso_i),
      .sck_en_o (sck_en_o),
      .ssel_o   (ssel_o),
      .mosi_o   (mosi_o)
   );

   // -------------------------------------------------------------------------
   // Clocks and watchdog
   // -------------------------------------------------------------------------

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // SPI clock offset so its edges never meet clk_i edges
   initial
   begin
      sck_i = 1'b0;
      #7;
      forever #30 sck_i = ~sck_i;
   end

   initial
   begin
      #(WATCHDOG_NS);
      abort_run("Watchdog expired before all transactions finished");
   end

   // -------------------------------------------------------------------------
   // Random numbers and checks
   // -------------------------------------------------------------------------

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] nxt;
      nxt = s >> 1;
      if (s[0])
         nxt = nxt ^ 16'hB400;
      return nxt;
   endfunction

   // Up to 8 stimulus bits, one LFSR step per bit
   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v = {v[6:0], stim_lfsr[0]};
         stim_lfsr = lfsr_step(stim_lfsr);
      end
      return v;
   endfunction

   function automatic spi_master_pkg::spi_byte_t next_reply();
      spi_master_pkg::spi_byte_t v;
      int i;
      v = '0;
      for (i = 0; i < 8; i++)
      begin
         v = {v[6:0], slv_lfsr[0]};
         slv_lfsr = lfsr_step(slv_lfsr);
      end
      return v;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_byte(input string name, input spi_master_pkg::spi_byte_t got,
                             input spi_master_pkg::spi_byte_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // -------------------------------------------------------------------------
   // SPI slave model
   // -------------------------------------------------------------------------

   initial
   begin : slave_model
      spi_master_pkg::spi_byte_t mosi_sr;
      spi_master_pkg::spi_byte_t reply_sr;
      spi_master_pkg::spi_byte_t reply_cur;
      int bit_cnt;
      logic window_new;
      slv_lfsr = 16'd69;
      reply_cur = next_reply();
      reply_sr = reply_cur;
      mosi_sr = '0;
      bit_cnt = 0;
      window_new = 1'b1;
      miso_i <= 1'b0;
      forever
      begin
         @(posedge sck_i or negedge sck_i);
         if (!sck_i)
         begin
            // Next reply bit ready before the rising edge
            miso_i <= reply_sr[7];
         end
         else if (ssel_o)
         begin
            bit_cnt = 0;
            window_new = 1'b1;
         end
         else if (sck_en_o)
         begin
            mosi_sr = {mosi_sr[6:0], mosi_o};
            reply_sr = {reply_sr[6:0], 1'b0};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8)
            begin
               mosi_q.push_back(mosi_sr);
               first_q.push_back(window_new);
               reply_q.push_back(reply_cur);
               window_new = 1'b0;
               reply_cur = next_reply();
               reply_sr = reply_cur;
               bit_cnt = 0;
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // Bus monitor
   // -------------------------------------------------------------------------

   // Values read here belong to the cycle that just ended
   always @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         // Ack follows each accepted strobe by one cycle and nothing else
         check_bit("ack_o", ack_o, prev_stb && prev_cyc && !prev_wat && !prev_ack);
         if (wat_o)
            wat_cycles = wat_cycles + 1;
         if (rdy_o)
         begin
            if (prev_rdy)
               abort_run("rdy_o stayed high for more than one cycle");
            else if (!cyc_i)
               abort_run("rdy_o pulsed while no bus cycle was open");
            else if (reply_q.size() == 0)
               abort_run("rdy_o pulsed with no byte returned by the SPI slave");
            else
            begin
               check_byte("dat_o", dat_o, reply_q.pop_front());
               rdy_count = rdy_count + 1;
            end
         end
      end
      prev_cyc = cyc_i;
      prev_stb = stb_i;
      prev_wat = wat_o;
      prev_ack = ack_o;
      prev_rdy = rdy_o;
   end

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------

   // One bus cycle of n data strobes, called on a rising clk_i edge
   task automatic run_transaction(input int n);
      logic [7:0] r;
      logic we;
      spi_master_pkg::spi_adr_t adr;
      int rdy_base;
      int i;
      r = take_bits(1);
      we = r[0];
      r = take_bits(7);
      adr = r[6:0];
      check_bit("ssel_o", ssel_o, 1'b1);
      exp_q.delete();
      exp_q.push_back({we, adr});
      rdy_base = rdy_count;
      cyc_i <= 1'b1;
      we_i  <= we;
      adr_i <= adr;
      for (i = 0; i < n; i++)
      begin
         r = take_bits(8);
         exp_q.push_back(r);
         stb_i <= 1'b1;
         dat_i <= r;
         // Strobe stays up until ack, then one low cycle
         do
            @(posedge clk_i);
         while (!ack_o);
         stb_i <= 1'b0;
         @(posedge clk_i);
      end
      // All bytes out on the wire and back on the bus
      while (mosi_q.size() < n + 1 || rdy_count - rdy_base < n + 1)
         @(posedge clk_i);
      cyc_i <= 1'b0;
      @(posedge clk_i);
      while (!ssel_o)
         @(posedge clk_i);
      check_count("mosi_o bytes", mosi_q.size(), n + 1);
      check_count("rdy_o pulses", rdy_count - rdy_base, n + 1);
      check_count("unreturned slave bytes", reply_q.size(), 0);
      for (i = 0; i <= n; i++)
      begin
         check_bit("window start", first_q.pop_front(), i == 0);
         check_byte("mosi_o", mosi_q.pop_front(), exp_q[i]);
      end
      // Idle gap before the next cycle
      r = take_bits(3);
      repeat (r[2:0])
         @(posedge clk_i);
   endtask

   initial
   begin : main_seq
      logic [7:0] r;
      int t;
      stim_lfsr = 16'd69;
      rdy_count = 0;
      wat_cycles = 0;
      rst_i <= 1'b1;
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      we_i  <= 1'b0;
      adr_i <= '0;
      dat_i <= '0;
      repeat (8)
         @(posedge clk_i);
      rst_i <= 1'b0;
      repeat (4)
         @(posedge clk_i);

      // Quiet outputs after reset
      check_bit("ssel_o", ssel_o, 1'b1);
      check_bit("sck_en_o", sck_en_o, 1'b0);
      check_bit("mosi_o", mosi_o, 1'b0);
      check_bit("ack_o", ack_o, 1'b0);
      check_bit("wat_o", wat_o, 1'b0);
      check_bit("rdy_o", rdy_o, 1'b0);

      // Long burst against the slow SPI clock overruns the TX FIFO
      run_transaction(20);
      if (wat_cycles == 0)
         abort_run("wat_o never rose while a 20 byte transaction filled the TX FIFO");

      for (t = 1; t < N_TRANS; t++)
      begin
         r = take_bits(5);
         run_transaction(1 + int'(r[4:0]) % 20);
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
